// ==== design/csr_settings.svh ====
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// Datapath widths
`define CSR_XLEN         64
`define CSR_ADDR_W       12
`define CSR_VADDR_W      39
`define CSR_ECODE_W      4
`define CSR_CAUSE_DEC_W  16
`define CSR_INSTR_W      32
`define CSR_HARTID_W     4

// User counter aliases
`define CSR_ADDR_CYCLE          12'hC00
`define CSR_ADDR_INSTRET        12'hC02

// Machine identity, read only
`define CSR_ADDR_MVENDORID      12'hF11
`define CSR_ADDR_MARCHID        12'hF12
`define CSR_ADDR_MIMPID         12'hF13
`define CSR_ADDR_MHARTID        12'hF14

// Machine trap setup and handling
`define CSR_ADDR_MSTATUS        12'h300
`define CSR_ADDR_MISA           12'h301
`define CSR_ADDR_MIE            12'h304
`define CSR_ADDR_MTVEC          12'h305
`define CSR_ADDR_MCOUNTEREN     12'h306
`define CSR_ADDR_MCOUNTINHIBIT  12'h320
`define CSR_ADDR_MSCRATCH       12'h340
`define CSR_ADDR_MEPC           12'h341
`define CSR_ADDR_MCAUSE         12'h342
`define CSR_ADDR_MTVAL          12'h343
`define CSR_ADDR_MIP            12'h344

// Machine counters
`define CSR_ADDR_MCYCLE         12'hB00
`define CSR_ADDR_MINSTRET       12'hB02

// Identity values
`define CSR_MVENDORID_VAL       64'd0
`define CSR_MARCHID_VAL         64'd13
`define CSR_MIMPID_VAL          64'd1
// MXLEN of 64, extensions A, I, S and U
`define CSR_MISA_VAL            {2'b10, 36'b0, 26'h140101}

// Cause code whose tval is the faulting instruction
`define CSR_CAUSE_ILLEGAL_INSTR 2

`endif

// ==== design/csr_pkg.sv ====
package csr_pkg;

`include "csr_settings.svh"

   typedef logic [`CSR_XLEN-1:0]        xlen_t;
   typedef logic [`CSR_ADDR_W-1:0]      csr_addr_t;
   typedef logic [`CSR_VADDR_W-1:0]     vaddr_t;
   typedef logic [`CSR_INSTR_W-1:0]     instr_t;
   typedef logic [`CSR_ECODE_W-1:0]     ecode_t;
   // One bit per cause code
   typedef logic [`CSR_CAUSE_DEC_W-1:0] cause_dec_t;
   typedef logic [`CSR_HARTID_W-1:0]    hartid_t;

   // Only machine and user mode exist
   typedef enum logic [1:0]
   {
      PRIV_U = 2'd0,
      PRIV_M = 2'd3
   } priv_e;

   // Command port operations
   typedef enum logic [3:0]
   {
      OP_CSRRW  = 4'd0,
      OP_CSRRS  = 4'd1,
      OP_CSRRC  = 4'd2,
      OP_CSRRWI = 4'd3,
      OP_CSRRSI = 4'd4,
      OP_CSRRCI = 4'd5,
      OP_MRET   = 4'd6,
      OP_ECALL  = 4'd7,
      OP_EBREAK = 4'd8,
      OP_WFI    = 4'd9
   } csr_op_e;

endpackage

// ==== design/csr_trap_if.sv ====
`timescale 1ns/10ps

interface csr_trap_if;
   import csr_pkg::*;

   // Trap controller to register file
   logic       take_trap;
   logic       trap_interrupt;
   ecode_t     trap_ecode;
   vaddr_t     trap_epc;
   xlen_t      trap_tval;
   logic       mret_commit;
   logic       mret_illegal;
   priv_e      priv;

   // Register file to trap controller
   logic       mstatus_mie;
   logic       mstatus_mpie;
   priv_e      mstatus_mpp;
   cause_dec_t irq_pending;

   modport ctrl
   (
      output take_trap, trap_interrupt, trap_ecode, trap_epc, trap_tval,
      output mret_commit, mret_illegal, priv,
      input  mstatus_mie, mstatus_mpie, mstatus_mpp, irq_pending
   );

   modport regs
   (
      input  take_trap, trap_interrupt, trap_ecode, trap_epc, trap_tval,
      input  mret_commit, mret_illegal, priv,
      output mstatus_mie, mstatus_mpie, mstatus_mpp, irq_pending
   );

endinterface

// ==== design/csr_counters.sv ====
`timescale 1ns/10ps

module csr_counters
(
   input  logic           clk_i,
   input  logic           arst_n_i,
   input  logic           instret_i,
   input  logic [1:0]     inhibit_i,
   input  logic           cycle_we_i,
   input  logic           instret_we_i,
   input  csr_pkg::xlen_t wdata_i,
   output csr_pkg::xlen_t mcycle_o,
   output csr_pkg::xlen_t minstret_o
);
   import csr_pkg::*;

   // Index 1 is mcycle, index 0 is minstret
   xlen_t      cnt_q [2];
   logic [1:0] we;
   logic [1:0] inc;

   assign we  = {cycle_we_i, instret_we_i};
   assign inc = {1'b1, instret_i} & ~inhibit_i;

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         cnt_q[0] <= '0;
         cnt_q[1] <= '0;
      end
      else
      begin
         for (int i = 0; i < 2; i++)
         begin
            // Software write wins over the count
            if (we[i])
               cnt_q[i] <= wdata_i;
            else if (inc[i])
               cnt_q[i] <= cnt_q[i] + xlen_t'(1);
         end
      end
   end

   assign mcycle_o   = cnt_q[1];
   assign minstret_o = cnt_q[0];

   a_we_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !$isunknown({cycle_we_i, instret_we_i}));

endmodule

// ==== design/csr_trap_ctrl.sv ====
`timescale 1ns/10ps
`include "csr_settings.svh"

module csr_trap_ctrl
(
   input  logic                clk_i,
   input  logic                arst_n_i,
   input  logic                csr_cmd_v_i,
   input  csr_pkg::csr_op_e    csr_op_i,
   input  logic                exception_v_i,
   input  csr_pkg::cause_dec_t exception_cause_i,
   input  csr_pkg::vaddr_t     exception_pc_i,
   input  csr_pkg::vaddr_t     exception_vaddr_i,
   input  csr_pkg::instr_t     exception_instr_i,
   input  csr_pkg::vaddr_t     interrupt_pc_i,
   csr_trap_if.ctrl            trap_if,
   output csr_pkg::priv_e      priv_mode_o
);
   import csr_pkg::*;

   priv_e      priv_q;
   logic       gie;
   cause_dec_t irq_masked;
   logic       exc_take;
   logic       irq_take;
   logic       mret_req;
   ecode_t     exc_code;
   ecode_t     irq_code;

   // Lowest set bit wins
   function automatic ecode_t lowest_set(cause_dec_t vec);
      ecode_t code;
      code = '0;
      for (int i = `CSR_CAUSE_DEC_W - 1; i >= 0; i--)
      begin
         if (vec[i])
            code = ecode_t'(i);
      end
      return code;
   endfunction

   // User mode always takes machine interrupts
   assign gie = (trap_if.mstatus_mie && (priv_q == PRIV_M)) || (priv_q == PRIV_U);
   assign irq_masked = trap_if.irq_pending & {`CSR_CAUSE_DEC_W{gie}};

   assign exc_take = exception_v_i & (|exception_cause_i);
   assign irq_take = ~exception_v_i & (|irq_masked);
   assign exc_code = lowest_set(exception_cause_i);
   assign irq_code = lowest_set(irq_masked);
   assign mret_req = csr_cmd_v_i && (csr_op_i == OP_MRET);

   assign trap_if.take_trap      = exc_take | irq_take;
   assign trap_if.trap_interrupt = irq_take;
   assign trap_if.trap_ecode     = irq_take ? irq_code : exc_code;
   assign trap_if.trap_epc       = irq_take ? interrupt_pc_i : exception_pc_i;

   always_comb
   begin
      if (irq_take)
         trap_if.trap_tval = '0;
      else if (exc_code == ecode_t'(`CSR_CAUSE_ILLEGAL_INSTR))
         trap_if.trap_tval = xlen_t'(exception_instr_i);
      else
         trap_if.trap_tval = xlen_t'(exception_vaddr_i);
   end

   // mret from user mode is illegal
   assign trap_if.mret_illegal = mret_req && (priv_q != PRIV_M);
   assign trap_if.mret_commit  = mret_req && (priv_q == PRIV_M) && !trap_if.take_trap;

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         priv_q <= PRIV_M;
      else if (trap_if.take_trap)
         priv_q <= PRIV_M;
      else if (trap_if.mret_commit)
         priv_q <= trap_if.mstatus_mpp;
   end

   assign trap_if.priv = priv_q;
   assign priv_mode_o  = priv_q;

   a_trap_mret_excl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !(trap_if.take_trap && trap_if.mret_commit));

   // Regfile restores mie from mpie after a committed mret
   a_mret_restore: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      trap_if.mret_commit |=> trap_if.mstatus_mie == $past(trap_if.mstatus_mpie));

endmodule

// ==== design/csr_regfile.sv ====
`timescale 1ns/10ps
`include "csr_settings.svh"

module csr_regfile
(
   input  logic               clk_i,
   input  logic               arst_n_i,
   input  logic               csr_cmd_v_i,
   input  csr_pkg::csr_op_e   csr_op_i,
   input  csr_pkg::csr_addr_t csr_addr_i,
   input  csr_pkg::xlen_t     csr_data_i,
   input  csr_pkg::hartid_t   hartid_i,
   input  logic               timer_irq_i,
   input  logic               software_irq_i,
   input  logic               external_irq_i,
   csr_trap_if.regs           trap_if,
   input  csr_pkg::xlen_t     mcycle_i,
   input  csr_pkg::xlen_t     minstret_i,
   output logic               cycle_we_o,
   output logic               instret_we_o,
   output csr_pkg::xlen_t     wdata_o,
   output logic [1:0]         inhibit_o,
   output csr_pkg::xlen_t     data_o,
   output logic               illegal_instr_o,
   output csr_pkg::vaddr_t    trap_epc_o,
   output csr_pkg::vaddr_t    trap_tvec_o
);
   import csr_pkg::*;

   // msie, mtie and meie
   localparam cause_dec_t IRQ_MASK = 16'h0888;

   logic       mstatus_mie_q;
   logic       mstatus_mpie_q;
   priv_e      mstatus_mpp_q;
   cause_dec_t mie_q;
   cause_dec_t mip_q;
   cause_dec_t irq_in;
   xlen_t      mtvec_q;
   xlen_t      mscratch_q;
   xlen_t      mepc_q;
   xlen_t      mcause_q;
   xlen_t      mtval_q;
   xlen_t      mcounteren_q;
   xlen_t      mcountinhibit_q;

   xlen_t      mstatus_rd;
   xlen_t      rdata;
   xlen_t      operand;
   xlen_t      csr_wdata;
   logic       known;
   logic       csr_access;
   logic       priv_low;
   logic       cnt_denied;
   logic       illegal;
   logic       csr_we;

   always_comb
   begin
      irq_in     = '0;
      irq_in[3]  = software_irq_i;
      irq_in[7]  = timer_irq_i;
      irq_in[11] = external_irq_i;
   end

   always_comb
   begin
      mstatus_rd        = '0;
      mstatus_rd[3]     = mstatus_mie_q;
      mstatus_rd[7]     = mstatus_mpie_q;
      mstatus_rd[12:11] = mstatus_mpp_q;
   end

   // Read mux
   always_comb
   begin
      rdata = '0;
      known = 1'b1;
      case (csr_addr_i)
         `CSR_ADDR_CYCLE, `CSR_ADDR_MCYCLE:     rdata = mcycle_i;
         `CSR_ADDR_INSTRET, `CSR_ADDR_MINSTRET: rdata = minstret_i;
         `CSR_ADDR_MVENDORID:     rdata = `CSR_MVENDORID_VAL;
         `CSR_ADDR_MARCHID:       rdata = `CSR_MARCHID_VAL;
         `CSR_ADDR_MIMPID:        rdata = `CSR_MIMPID_VAL;
         `CSR_ADDR_MHARTID:       rdata = xlen_t'(hartid_i);
         `CSR_ADDR_MSTATUS:       rdata = mstatus_rd;
         `CSR_ADDR_MISA:          rdata = `CSR_MISA_VAL;
         `CSR_ADDR_MIE:           rdata = xlen_t'(mie_q);
         `CSR_ADDR_MTVEC:         rdata = mtvec_q;
         `CSR_ADDR_MCOUNTEREN:    rdata = mcounteren_q;
         `CSR_ADDR_MCOUNTINHIBIT: rdata = mcountinhibit_q;
         `CSR_ADDR_MSCRATCH:      rdata = mscratch_q;
         `CSR_ADDR_MEPC:          rdata = mepc_q;
         `CSR_ADDR_MCAUSE:        rdata = mcause_q;
         `CSR_ADDR_MTVAL:         rdata = mtval_q;
         `CSR_ADDR_MIP:           rdata = xlen_t'(mip_q);
         default:                 known = 1'b0;
      endcase
   end

   // Read-modify-write value
   always_comb
   begin
      operand = csr_data_i;
      if (csr_op_i inside {OP_CSRRWI, OP_CSRRSI, OP_CSRRCI})
         operand = xlen_t'(csr_data_i[4:0]);
      case (csr_op_i)
         OP_CSRRW, OP_CSRRWI: csr_wdata = operand;
         OP_CSRRS, OP_CSRRSI: csr_wdata = rdata | operand;
         OP_CSRRC, OP_CSRRCI: csr_wdata = rdata & ~operand;
         default:             csr_wdata = rdata;
      endcase
   end

   // Access checks
   assign csr_access = csr_cmd_v_i &&
      (csr_op_i inside {OP_CSRRW, OP_CSRRS, OP_CSRRC, OP_CSRRWI, OP_CSRRSI, OP_CSRRCI});
   assign priv_low   = trap_if.priv < csr_addr_i[9:8];
   assign cnt_denied = (trap_if.priv == PRIV_U) &&
      (((csr_addr_i == `CSR_ADDR_CYCLE) && !mcounteren_q[0]) ||
       ((csr_addr_i == `CSR_ADDR_INSTRET) && !mcounteren_q[2]));
   assign illegal = trap_if.mret_illegal || (csr_access && (!known || priv_low || cnt_denied));

   // Address bits 11:10 set mark a read-only CSR; a trap cancels the write
   assign csr_we = csr_access && !illegal && (csr_addr_i[11:10] != 2'b11) &&
                   !trap_if.take_trap;

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         mstatus_mie_q   <= 1'b0;
         mstatus_mpie_q  <= 1'b0;
         mstatus_mpp_q   <= PRIV_U;
         mie_q           <= '0;
         mip_q           <= '0;
         mtvec_q         <= '0;
         mscratch_q      <= '0;
         mepc_q          <= '0;
         mcause_q        <= '0;
         mtval_q         <= '0;
         mcounteren_q    <= '0;
         mcountinhibit_q <= '0;
      end
      else
      begin
         mip_q <= irq_in;
         if (csr_we)
         begin
            case (csr_addr_i)
               `CSR_ADDR_MSTATUS:
               begin
                  mstatus_mie_q  <= csr_wdata[3];
                  mstatus_mpie_q <= csr_wdata[7];
                  // WARL field that reads anything but M back as U
                  mstatus_mpp_q  <= (csr_wdata[12:11] == PRIV_M) ? PRIV_M : PRIV_U;
               end
               `CSR_ADDR_MIE:           mie_q <= cause_dec_t'(csr_wdata) & IRQ_MASK;
               `CSR_ADDR_MTVEC:         mtvec_q <= csr_wdata;
               `CSR_ADDR_MCOUNTEREN:    mcounteren_q <= csr_wdata;
               `CSR_ADDR_MCOUNTINHIBIT: mcountinhibit_q <= csr_wdata;
               `CSR_ADDR_MSCRATCH:      mscratch_q <= csr_wdata;
               `CSR_ADDR_MEPC:          mepc_q <= csr_wdata;
               `CSR_ADDR_MCAUSE:        mcause_q <= csr_wdata;
               `CSR_ADDR_MTVAL:         mtval_q <= csr_wdata;
               default:;
            endcase
         end
         if (trap_if.take_trap)
         begin
            mepc_q         <= xlen_t'(trap_if.trap_epc);
            mtval_q        <= trap_if.trap_tval;
            mcause_q       <= {trap_if.trap_interrupt, {(`CSR_XLEN - `CSR_ECODE_W - 1){1'b0}},
                               trap_if.trap_ecode};
            mstatus_mpp_q  <= trap_if.priv;
            mstatus_mpie_q <= mstatus_mie_q;
            mstatus_mie_q  <= 1'b0;
         end
         else if (trap_if.mret_commit)
         begin
            mstatus_mie_q  <= mstatus_mpie_q;
            mstatus_mpie_q <= 1'b1;
            mstatus_mpp_q  <= PRIV_U;
         end
      end
   end

   assign trap_if.mstatus_mie  = mstatus_mie_q;
   assign trap_if.mstatus_mpie = mstatus_mpie_q;
   assign trap_if.mstatus_mpp  = mstatus_mpp_q;
   assign trap_if.irq_pending  = mie_q & mip_q;

   // Counter side
   assign cycle_we_o   = csr_we && (csr_addr_i == `CSR_ADDR_MCYCLE);
   assign instret_we_o = csr_we && (csr_addr_i == `CSR_ADDR_MINSTRET);
   assign wdata_o      = csr_wdata;
   assign inhibit_o    = {mcountinhibit_q[0], mcountinhibit_q[2]};

   assign data_o          = rdata;
   assign illegal_instr_o = illegal;
   assign trap_epc_o      = mepc_q[`CSR_VADDR_W-1:0];
   assign trap_tvec_o     = mtvec_q[`CSR_VADDR_W-1:0];

endmodule

// ==== design/csr_unit.sv ====
`timescale 1ns/10ps

module csr_unit
(
   input  logic                clk_i,
   input  logic                arst_n_i,
   input  logic                csr_cmd_v_i,
   input  csr_pkg::csr_op_e    csr_op_i,
   input  csr_pkg::csr_addr_t  csr_addr_i,
   input  csr_pkg::xlen_t      csr_data_i,
   output csr_pkg::xlen_t      data_o,
   output logic                v_o,
   output logic                illegal_instr_o,
   input  csr_pkg::hartid_t    hartid_i,
   input  logic                instret_i,
   input  logic                exception_v_i,
   input  csr_pkg::cause_dec_t exception_cause_i,
   input  csr_pkg::vaddr_t     exception_pc_i,
   input  csr_pkg::vaddr_t     exception_vaddr_i,
   input  csr_pkg::instr_t     exception_instr_i,
   input  csr_pkg::vaddr_t     interrupt_pc_i,
   input  logic                timer_irq_i,
   input  logic                software_irq_i,
   input  logic                external_irq_i,
   output logic                trap_exception_o,
   output logic                trap_interrupt_o,
   output logic                trap_eret_o,
   output csr_pkg::vaddr_t     trap_epc_o,
   output csr_pkg::vaddr_t     trap_tvec_o,
   output csr_pkg::priv_e      priv_mode_o
);
   import csr_pkg::*;

   xlen_t      mcycle;
   xlen_t      minstret;
   xlen_t      cnt_wdata;
   logic       cycle_we;
   logic       instret_we;
   logic [1:0] inhibit;

   csr_trap_if trap_if_inst();

   csr_trap_ctrl csr_trap_ctrl_inst
   (
      .clk_i             (clk_i),
      .arst_n_i          (arst_n_i),
      .csr_cmd_v_i       (csr_cmd_v_i),
      .csr_op_i          (csr_op_i),
      .exception_v_i     (exception_v_i),
      .exception_cause_i (exception_cause_i),
      .exception_pc_i    (exception_pc_i),
      .exception_vaddr_i (exception_vaddr_i),
      .exception_instr_i (exception_instr_i),
      .interrupt_pc_i    (interrupt_pc_i),
      .trap_if           (trap_if_inst.ctrl),
      .priv_mode_o       (priv_mode_o)
   );

   csr_regfile csr_regfile_inst
   (
      .clk_i           (clk_i),
      .arst_n_i        (arst_n_i),
      .csr_cmd_v_i     (csr_cmd_v_i),
      .csr_op_i        (csr_op_i),
      .csr_addr_i      (csr_addr_i),
      .csr_data_i      (csr_data_i),
      .hartid_i        (hartid_i),
      .timer_irq_i     (timer_irq_i),
      .software_irq_i  (software_irq_i),
      .external_irq_i  (external_irq_i),
      .trap_if         (trap_if_inst.regs),
      .mcycle_i        (mcycle),
      .minstret_i      (minstret),
      .cycle_we_o      (cycle_we),
      .instret_we_o    (instret_we),
      .wdata_o         (cnt_wdata),
      .inhibit_o       (inhibit),
      .data_o          (data_o),
      .illegal_instr_o (illegal_instr_o),
      .trap_epc_o      (trap_epc_o),
      .trap_tvec_o     (trap_tvec_o)
   );

   csr_counters csr_counters_inst
   (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .instret_i    (instret_i),
      .inhibit_i    (inhibit),
      .cycle_we_i   (cycle_we),
      .instret_we_i (instret_we),
      .wdata_i      (cnt_wdata),
      .mcycle_o     (mcycle),
      .minstret_o   (minstret)
   );

   assign v_o              = csr_cmd_v_i;
   assign trap_exception_o = trap_if_inst.take_trap & ~trap_if_inst.trap_interrupt;
   assign trap_interrupt_o = trap_if_inst.trap_interrupt;
   assign trap_eret_o      = trap_if_inst.mret_commit;

endmodule

// ==== verification/tb_csr_unit.sv ====
`timescale 1ns/10ps
`include "csr_settings.svh"

module tb_csr_unit;
   import csr_pkg::*;

   // MXLEN 64 with A, I, S and U
   localparam xlen_t MISA_EXP = (xlen_t'(2) << 62) | (xlen_t'(1) << 0) | (xlen_t'(1) << 8) |
                                (xlen_t'(1) << 18) | (xlen_t'(1) << 20);
   localparam int IDX_MSCRATCH = 0;
   localparam int IDX_MTVEC    = 1;
   localparam int IDX_MEPC     = 2;

   logic       clk_i;
   logic       arst_n_i;
   logic       csr_cmd_v_i;
   csr_op_e    csr_op_i;
   csr_addr_t  csr_addr_i;
   xlen_t      csr_data_i;
   xlen_t      data_o;
   logic       v_o;
   logic       illegal_instr_o;
   hartid_t    hartid_i;
   logic       instret_i;
   logic       exception_v_i;
   cause_dec_t exception_cause_i;
   vaddr_t     exception_pc_i;
   vaddr_t     exception_vaddr_i;
   instr_t     exception_instr_i;
   vaddr_t     interrupt_pc_i;
   logic       timer_irq_i;
   logic       software_irq_i;
   logic       external_irq_i;
   logic       trap_exception_o;
   logic       trap_interrupt_o;
   logic       trap_eret_o;
   vaddr_t     trap_epc_o;
   vaddr_t     trap_tvec_o;
   priv_e      priv_mode_o;

   // Expectations for the coming rising edge
   logic       chk_data;
   logic       chk_cmd;
   logic       chk_trap;
   xlen_t      exp_data;
   logic       exp_ill;
   logic       exp_exc;
   logic       exp_int;
   logic       exp_eret;
   priv_e      exp_priv;
   vaddr_t     exp_epc;
   vaddr_t     exp_tvec;

   // Reference model state
   xlen_t      m_reg [3];
   xlen_t      m_mcause;
   xlen_t      m_mtval;
   logic       m_mie;
   logic       m_mpie;
   priv_e      m_mpp;
   priv_e      m_priv;

   logic [63:0] rng;
   int          checks;
   int          errors;
   int          timeouts;
   int          chk_mark;
   int          err_mark;

   csr_unit csr_unit_inst (.*);

   always #20 clk_i = ~clk_i;

   function automatic logic [63:0] xorshift(logic [63:0] s);
      logic [63:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 7);
      x = x ^ (x << 17);
      return x;
   endfunction

   function automatic xlen_t next_rand();
      rng = xorshift(rng);
      return rng;
   endfunction

   // Expected CSR value after one read-modify-write
   function automatic xlen_t ref_rmw(csr_op_e op, xlen_t old, xlen_t arg);
      xlen_t opnd;
      xlen_t res;
      opnd = arg;
      if (op == OP_CSRRWI || op == OP_CSRRSI || op == OP_CSRRCI)
         opnd = {59'b0, arg[4:0]};
      case (op)
         OP_CSRRW, OP_CSRRWI: res = opnd;
         OP_CSRRS, OP_CSRRSI: res = old | opnd;
         OP_CSRRC, OP_CSRRCI: res = old & ~opnd;
         default:             res = old;
      endcase
      return res;
   endfunction

   function automatic xlen_t mstatus_val();
      xlen_t v;
      v        = '0;
      v[3]     = m_mie;
      v[7]     = m_mpie;
      v[12:11] = m_mpp;
      return v;
   endfunction

   // Priority goes to the smallest cause code
   function automatic ecode_t first_cause(cause_dec_t vec);
      ecode_t code;
      logic   found;
      code  = '0;
      found = 1'b0;
      for (int i = 0; i < 16; i++)
      begin
         if (vec[i] && !found)
         begin
            code  = ecode_t'(i);
            found = 1'b1;
         end
      end
      return code;
   endfunction

   function automatic csr_addr_t reg_addr(int idx);
      case (idx)
         IDX_MSCRATCH: return `CSR_ADDR_MSCRATCH;
         IDX_MTVEC:    return `CSR_ADDR_MTVEC;
         default:      return `CSR_ADDR_MEPC;
      endcase
   endfunction

   task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      assert (got === exp)
      else
      begin
         errors++;
         $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   // Compare process, outputs are settled half a period after the drive
   always @(posedge clk_i)
   begin
      if (chk_data)
         check_val("data_o", data_o, exp_data);
      if (chk_cmd)
      begin
         check_val("v_o", 64'(v_o), 64'(csr_cmd_v_i));
         check_val("illegal_instr_o", 64'(illegal_instr_o), 64'(exp_ill));
         check_val("priv_mode_o", 64'(priv_mode_o), 64'(exp_priv));
         check_val("trap_exception_o", 64'(trap_exception_o), 64'(exp_exc));
         check_val("trap_interrupt_o", 64'(trap_interrupt_o), 64'(exp_int));
         check_val("trap_eret_o", 64'(trap_eret_o), 64'(exp_eret));
      end
      if (chk_trap)
      begin
         check_val("trap_epc_o", 64'(trap_epc_o), 64'(exp_epc));
         check_val("trap_tvec_o", 64'(trap_tvec_o), 64'(exp_tvec));
      end
   end

   task automatic idle();
      @(negedge clk_i);
      csr_cmd_v_i   = 1'b0;
      exception_v_i = 1'b0;
      instret_i     = 1'b0;
      chk_data      = 1'b0;
      chk_cmd       = 1'b0;
      chk_trap      = 1'b0;
   endtask

   task automatic csr_cmd(input csr_op_e op, input csr_addr_t addr, input xlen_t data,
                          input logic chk_rd, input xlen_t exp_rd, input logic ill);
      @(negedge clk_i);
      csr_cmd_v_i   = 1'b1;
      csr_op_i      = op;
      csr_addr_i    = addr;
      csr_data_i    = data;
      exception_v_i = 1'b0;
      chk_data      = chk_rd;
      exp_data      = exp_rd;
      chk_cmd       = 1'b1;
      chk_trap      = 1'b0;
      exp_ill       = ill;
      exp_priv      = m_priv;
      exp_exc       = 1'b0;
      exp_int       = 1'b0;
      exp_eret      = 1'b0;
   endtask

   // CSRRS with a zero operand leaves the value as it is
   task automatic csr_read(input csr_addr_t addr, input xlen_t exp_rd);
      csr_cmd(OP_CSRRS, addr, '0, 1'b1, exp_rd, 1'b0);
   endtask

   task automatic expect_trap(input logic exc, input logic irq, input logic eret);
      chk_cmd  = 1'b1;
      chk_trap = 1'b1;
      exp_ill  = 1'b0;
      exp_priv = m_priv;
      exp_exc  = exc;
      exp_int  = irq;
      exp_eret = eret;
      exp_epc  = vaddr_t'(m_reg[IDX_MEPC]);
      exp_tvec = vaddr_t'(m_reg[IDX_MTVEC]);
   endtask

   task automatic apply_trap(input logic irq, input ecode_t code, input vaddr_t epc,
                             input xlen_t tval);
      m_reg[IDX_MEPC] = xlen_t'(epc);
      m_mcause        = {irq, 59'b0, code};
      m_mtval         = tval;
      m_mpp           = m_priv;
      m_mpie          = m_mie;
      m_mie           = 1'b0;
      m_priv          = PRIV_M;
   endtask

   task automatic raise_exception(input cause_dec_t cause);
      vaddr_t pc;
      vaddr_t va;
      instr_t ins;
      ecode_t code;
      xlen_t  tval;
      pc   = vaddr_t'(next_rand());
      va   = vaddr_t'(next_rand());
      ins  = instr_t'(next_rand());
      code = first_cause(cause);
      // Illegal instruction reports the instruction word
      tval = (code == ecode_t'(2)) ? xlen_t'(ins) : xlen_t'(va);
      @(negedge clk_i);
      csr_cmd_v_i       = 1'b0;
      exception_v_i     = 1'b1;
      exception_cause_i = cause;
      exception_pc_i    = pc;
      exception_vaddr_i = va;
      exception_instr_i = ins;
      chk_data          = 1'b0;
      expect_trap(1'b1, 1'b0, 1'b0);
      apply_trap(1'b0, code, pc, tval);
   endtask

   task automatic do_mret();
      csr_cmd(OP_MRET, '0, '0, 1'b0, '0, 1'b0);
      expect_trap(1'b0, 1'b0, 1'b1);
      m_priv = m_mpp;
      m_mie  = m_mpie;
      m_mpie = 1'b1;
      m_mpp  = PRIV_U;
   endtask

   task automatic end_test(input int num, input string name);
      idle();
      $display("Test %0d %s: %0d checks, %0d errors", num, name, checks - chk_mark,
               errors - err_mark);
      chk_mark = checks;
      err_mark = errors;
   endtask

   initial
   begin
      int         idx;
      int         n;
      int         cyc;
      logic       found;
      csr_op_e    op;
      xlen_t      val;
      cause_dec_t cause;

      rng               = 64'd68806;
      clk_i             = 1'b0;
      arst_n_i          = 1'b0;
      csr_cmd_v_i       = 1'b0;
      csr_op_i          = OP_CSRRS;
      csr_addr_i        = '0;
      csr_data_i        = '0;
      hartid_i          = hartid_t'(next_rand());
      instret_i         = 1'b0;
      exception_v_i     = 1'b0;
      exception_cause_i = '0;
      exception_pc_i    = '0;
      exception_vaddr_i = '0;
      exception_instr_i = '0;
      interrupt_pc_i    = vaddr_t'(next_rand());
      timer_irq_i       = 1'b0;
      software_irq_i    = 1'b0;
      external_irq_i    = 1'b0;
      chk_data          = 1'b0;
      chk_cmd           = 1'b0;
      chk_trap          = 1'b0;
      m_reg[0]          = '0;
      m_reg[1]          = '0;
      m_reg[2]          = '0;
      m_mcause          = '0;
      m_mtval           = '0;
      m_mie             = 1'b0;
      m_mpie            = 1'b0;
      m_mpp             = PRIV_U;
      m_priv            = PRIV_M;
      checks            = 0;
      errors            = 0;
      timeouts          = 0;
      chk_mark          = 0;
      err_mark          = 0;

      repeat (3) @(posedge clk_i);
      @(negedge clk_i);
      arst_n_i = 1'b1;

      csr_read(`CSR_ADDR_MSTATUS, '0);
      csr_read(`CSR_ADDR_MISA, MISA_EXP);
      csr_read(`CSR_ADDR_MARCHID, 64'd13);
      csr_read(`CSR_ADDR_MIMPID, 64'd1);
      csr_read(`CSR_ADDR_MHARTID, xlen_t'(hartid_i));
      end_test(1, "reset values");

      // Each command returns the value left by the one before
      for (int i = 0; i < 40; i++)
      begin
         idx = int'(next_rand() % 64'd3);
         op  = csr_op_e'(4'(next_rand() % 64'd6));
         val = next_rand();
         csr_cmd(op, reg_addr(idx), val, 1'b1, m_reg[idx], 1'b0);
         m_reg[idx] = ref_rmw(op, m_reg[idx], val);
      end
      for (int i = 0; i < 3; i++)
         csr_read(reg_addr(i), m_reg[i]);
      end_test(2, "random read-modify-write");

      for (int i = 0; i < 2; i++)
      begin
         cause = cause_dec_t'(next_rand());
         if (i == 1)
            cause = (cause & 16'hFFF8) | 16'h0004;
         if (cause == '0)
            cause = 16'h0001;
         raise_exception(cause);
         csr_read(`CSR_ADDR_MCAUSE, m_mcause);
         csr_read(`CSR_ADDR_MEPC, m_reg[IDX_MEPC]);
         csr_read(`CSR_ADDR_MTVAL, m_mtval);
         csr_read(`CSR_ADDR_MSTATUS, mstatus_val());
      end
      end_test(3, "exception trap");

      csr_cmd(OP_CSRRC, `CSR_ADDR_MSTATUS, 64'h1800, 1'b1, mstatus_val(), 1'b0);
      m_mpp = PRIV_U;
      do_mret();
      csr_cmd(OP_CSRRW, `CSR_ADDR_MSCRATCH, next_rand(), 1'b0, '0, 1'b1);
      csr_cmd(OP_CSRRS, `CSR_ADDR_CYCLE, '0, 1'b0, '0, 1'b1);
      // Ecall from user mode gets back to machine mode
      raise_exception(16'h0100);
      csr_read(`CSR_ADDR_MSCRATCH, m_reg[IDX_MSCRATCH]);
      csr_cmd(OP_CSRRW, `CSR_ADDR_MCOUNTEREN, 64'h1, 1'b1, '0, 1'b0);
      csr_read(`CSR_ADDR_MSTATUS, mstatus_val());
      do_mret();
      csr_cmd(OP_CSRRS, `CSR_ADDR_CYCLE, '0, 1'b0, '0, 1'b0);
      raise_exception(16'h0100);
      end_test(4, "mret and user access");

      csr_cmd(OP_CSRRW, `CSR_ADDR_MIE, 64'h88, 1'b1, '0, 1'b0);
      csr_cmd(OP_CSRRS, `CSR_ADDR_MSTATUS, 64'h8, 1'b1, mstatus_val(), 1'b0);
      m_mie = 1'b1;
      idle();
      timer_irq_i    = 1'b1;
      software_irq_i = 1'b1;
      found          = 1'b0;
      cyc            = 0;
      while (!found && cyc < 20)
      begin
         @(negedge clk_i);
         cyc++;
         found = trap_interrupt_o;
      end
      if (found)
      begin
         expect_trap(1'b0, 1'b1, 1'b0);
         apply_trap(1'b1, ecode_t'(3), interrupt_pc_i, '0);
      end
      else
      begin
         timeouts++;
         $display("Timeout: no interrupt taken within %0d cycles", cyc);
      end
      timer_irq_i    = 1'b0;
      software_irq_i = 1'b0;
      csr_read(`CSR_ADDR_MCAUSE, m_mcause);
      csr_read(`CSR_ADDR_MEPC, m_reg[IDX_MEPC]);
      csr_read(`CSR_ADDR_MTVAL, m_mtval);
      csr_read(`CSR_ADDR_MSTATUS, mstatus_val());
      end_test(5, "machine interrupt");

      // Both counters stopped
      csr_cmd(OP_CSRRW, `CSR_ADDR_MCOUNTINHIBIT, 64'h5, 1'b1, '0, 1'b0);
      val = next_rand();
      csr_cmd(OP_CSRRW, `CSR_ADDR_MCYCLE, val, 1'b0, '0, 1'b0);
      csr_read(`CSR_ADDR_MCYCLE, val);
      idle();
      idle();
      csr_read(`CSR_ADDR_MCYCLE, val);
      csr_cmd(OP_CSRRW, `CSR_ADDR_MCOUNTINHIBIT, 64'h1, 1'b1, 64'h5, 1'b0);
      val = next_rand();
      csr_cmd(OP_CSRRW, `CSR_ADDR_MINSTRET, val, 1'b0, '0, 1'b0);
      n = 3 + int'(next_rand() % 64'd5);
      for (int i = 0; i < n; i++)
      begin
         idle();
         instret_i = 1'b1;
         idle();
      end
      csr_read(`CSR_ADDR_MINSTRET, val + xlen_t'(n));
      csr_cmd(OP_CSRRS, 12'h345, '0, 1'b0, '0, 1'b1);
      end_test(6, "counters and unknown address");

      $display("Summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0)
      begin
         $display("Everything OK");
      end
      else
      begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// ==== vlog.f ====
+incdir+design
design/csr_pkg.sv
design/csr_trap_if.sv
design/csr_counters.sv
design/csr_trap_ctrl.sv
design/csr_regfile.sv
design/csr_unit.sv
verification/tb_csr_unit.sv

// ==== run_verilator.sh ====
#!/bin/sh
# Build and run the CSR unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_csr_unit -Mdir obj_dir

./obj_dir/Vtb_csr_unit | tee sim.log

if grep -qx "Everything OK" sim.log; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed"
   exit 1
fi
